// ==== source/ulaPkg.sv ====
`default_nettype none

package ulaPkg;

   ////////////////////
   // Raster geometry

   // Clocks per line and lines per frame
   localparam int hTotal = 448;
   localparam int vTotal = 312;

   // Paper area
   localparam int paperWidth = 256;
   localparam int paperHeight = 192;

   // Frame interrupt window
   localparam int intLine = 248;
   localparam int intLength = 32;

   // Paper column x shows up at hCount = x + pixelLead
   localparam int pixelLead = 16;

   ////////////////////
   // Port addresses

   localparam logic [15:0] portUlaPlusReg = 16'hBF3B;
   localparam logic [15:0] portUlaPlusData = 16'hFF3B;

   ////////////////////
   // Types

   typedef logic [8:0] vCount_t;
   // GGGRRRBBB
   typedef logic [8:0] colour9_t;
   typedef logic [5:0] paletteIndex_t;
   // GGGRRRBB
   typedef logic [7:0] paletteEntry_t;

   // Fetch slot phases
   typedef enum logic [2:0] {
      idle,
      bitmapAddr,
      bitmapLoad,
      attrAddr,
      attrLoad
   } fetchPhase_e;

endpackage

`default_nettype wire

// ==== source/paletteIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface paletteIf
   import ulaPkg::*;
();

   // Driven by the client
   logic req;
   logic write;
   paletteIndex_t addr;
   paletteEntry_t wdata;

   // Driven by the arbiter
   logic grant;
   // Valid one cycle after grant
   paletteEntry_t rdata;

   modport client (output req, write, addr, wdata, input grant, rdata);
   modport arbiter (input req, write, addr, wdata, output grant, rdata);

endinterface

`default_nettype wire

// ==== source/ulaRasterTiming.sv ====
`timescale 1ns/1ps
`default_nettype none

module ulaRasterTiming
   import ulaPkg::*;
#(
   parameter int hTotal = ulaPkg::hTotal,
   parameter int vTotal = ulaPkg::vTotal
) (
   input wire logic clk7,
   input wire logic rst_n,
   output vCount_t hCount,
   output vCount_t vCount,
   output logic hsync,
   output logic vsync,
   output logic intN
);

   // Sync positions inside the blanking regions
   localparam int hSyncStart = 344;
   localparam int hSyncLength = 32;
   localparam int vSyncStart = 248;
   localparam int vSyncLength = 4;

   ////////////////////
   // Counters

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         hCount <= '0;
         vCount <= '0;
      end else if (hCount == vCount_t'(hTotal - 1)) begin
         hCount <= '0;
         // Line wrap steps the frame counter
         if (vCount == vCount_t'(vTotal - 1))
            vCount <= '0;
         else
            vCount <= vCount + 1'b1;
      end else begin
         hCount <= hCount + 1'b1;
      end
   end

   ////////////////////
   // Sync and interrupt

   // Active high pulses, decoded straight from the counters
   assign hsync = (hCount >= hSyncStart) && (hCount < hSyncStart + hSyncLength);
   assign vsync = (vCount >= vSyncStart) && (vCount < vSyncStart + vSyncLength);

   // Interrupt low for the first clocks of the interrupt line
   assign intN = !((vCount == intLine) && (hCount < intLength));

endmodule

`default_nettype wire

// ==== source/ulaVideoFetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module ulaVideoFetch
   import ulaPkg::*;
(
   input wire logic clk7,
   input wire logic rst_n,
   input wire vCount_t hCount,
   input wire vCount_t vCount,
   input wire logic [7:0] vramData,
   output logic [13:0] vramAddr,
   output logic pixel,
   output logic [7:0] attrNext,
   output logic paperActive
);

   fetchPhase_e fetchPhase;
   logic fetchWindow;
   logic [4:0] column;
   logic [7:0] bitmapReg;
   logic [7:0] attrReg;
   logic [7:0] shifter;

   ////////////////////
   // Windows

   // Fetch runs 8 clocks ahead of the serializer
   assign fetchWindow = (hCount < paperWidth) && (vCount < paperHeight);
   assign paperActive = (hCount >= 8) && (hCount < paperWidth + 8) && (vCount < paperHeight);

   ////////////////////
   // Fetch sequencer

   // Two bitmap/attr pairs per 16-clock slot
   always_comb begin
      fetchPhase = idle;
      if (fetchWindow) begin
         case (hCount[3:0])
            4'd8, 4'd12: fetchPhase = bitmapAddr;
            4'd9, 4'd13: fetchPhase = bitmapLoad;
            4'd10, 4'd14: fetchPhase = attrAddr;
            4'd11, 4'd15: fetchPhase = attrLoad;
            default: fetchPhase = idle;
         endcase
      end
   end

   // Column for the next cell, taken mid-cell
   always_ff @(posedge clk7) begin
      if (!rst_n)
         column <= '0;
      else if (hCount[2:0] == 3'd3)
         column <= hCount[7:3];
   end

   // Interleaved bitmap layout, attributes from 0x1800
   always_comb begin
      case (fetchPhase)
         attrAddr, attrLoad: vramAddr = {4'b0110, vCount[7:3], column};
         default: vramAddr = {1'b0, vCount[7:6], vCount[2:0], vCount[5:3], column};
      endcase
   end

   ////////////////////
   // Data registers

   always_ff @(posedge clk7) begin
      if (fetchPhase == bitmapLoad)
         bitmapReg <= vramData;
      if (fetchPhase == attrLoad)
         attrReg <= vramData;
   end

   assign attrNext = attrReg;

   // One pixel per clock, zeros shifted in past the last cell
   always_ff @(posedge clk7) begin
      if (!rst_n)
         shifter <= '0;
      else if (paperActive && (hCount[2:0] == 3'd4))
         shifter <= bitmapReg;
      else
         shifter <= {shifter[6:0], 1'b0};
   end

   assign pixel = shifter[7];

endmodule

`default_nettype wire

// ==== source/ulaPaletteArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module ulaPaletteArbiter
   import ulaPkg::*;
(
   input wire logic clk7,
   input wire logic rst_n,
   paletteIf.arbiter videoPal,
   paletteIf.arbiter cpuPal
);

   // 64 GGGRRRBB entries
   paletteEntry_t paletteMem [64];

   paletteIndex_t selAddr;
   paletteEntry_t selWdata;
   logic selWrite;
   paletteEntry_t videoQ;
   paletteEntry_t cpuQ;

   ////////////////////
   // Grant

   // Video has fixed priority, CPU takes the gaps
   assign videoPal.grant = videoPal.req;
   assign cpuPal.grant = cpuPal.req && !videoPal.req;

   // Single port, so one address per clock
   always_comb begin
      if (videoPal.req) begin
         selAddr = videoPal.addr;
         selWdata = videoPal.wdata;
         selWrite = videoPal.write;
      end else begin
         selAddr = cpuPal.addr;
         selWdata = cpuPal.wdata;
         selWrite = cpuPal.write && cpuPal.req;
      end
   end

   ////////////////////
   // Memory

   always_ff @(posedge clk7) begin
      if (selWrite)
         paletteMem[selAddr] <= selWdata;
   end

   // Per-client read registers, each held until its next read
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         videoQ <= '0;
         cpuQ <= '0;
      end else begin
         if (videoPal.grant && !videoPal.write)
            videoQ <= paletteMem[selAddr];
         if (cpuPal.grant && !cpuPal.write)
            cpuQ <= paletteMem[selAddr];
      end
   end

   assign videoPal.rdata = videoQ;
   assign cpuPal.rdata = cpuQ;

endmodule

`default_nettype wire

// ==== source/ulaPixelColour.sv ====
`timescale 1ns/1ps
`default_nettype none

module ulaPixelColour
   import ulaPkg::*;
(
   input wire logic clk7,
   input wire logic rst_n,
   input wire vCount_t hCount,
   input wire vCount_t vCount,
   input wire logic pixel,
   input wire logic [7:0] attrNext,
   input wire logic paperActive,
   input wire logic [2:0] border,
   input wire logic ulaPlusEnabled,
   paletteIf.client videoPal,
   output logic [2:0] r,
   output logic [2:0] g,
   output logic [2:0] b
);

   // Cell attribute and palette entries move to the output stage here
   localparam logic [2:0] latchPhase = 3'((pixelLead - 2) % 8);
   // Paper entry first, ink entry lands on rdata in the latch cycle
   localparam logic [2:0] paperReqPhase = latchPhase - 3'd2;
   localparam logic [2:0] inkReqPhase = latchPhase - 3'd1;

   logic inPaper;
   logic [7:0] effAttr;
   logic paperGrantQ;
   paletteEntry_t paperHold;
   paletteEntry_t paperEntry;
   paletteEntry_t inkEntry;
   logic [7:0] attrQ;
   logic pixelQ1;
   logic pixelQ2;
   logic [3:0] stdIgrb;
   paletteEntry_t plusEntry;
   colour9_t finalColour;

   // IGRB to GGGRRRBBB, half level 101 and bright level 111
   function automatic colour9_t stdColour(input logic [3:0] igrb);
      logic [2:0] level;
      level = igrb[3] ? 3'b111 : 3'b101;
      return {igrb[2] ? level : 3'b000, igrb[1] ? level : 3'b000, igrb[0] ? level : 3'b000};
   endfunction

   ////////////////////
   // Effective attribute

   assign inPaper = paperActive && (vCount < paperHeight);

   // Border as paper, black ink, no bright
   assign effAttr = inPaper ? attrNext : {2'b00, border, 3'b000};

   ////////////////////
   // Palette requests

   assign videoPal.req = (hCount[2:0] == paperReqPhase) || (hCount[2:0] == inkReqPhase);
   assign videoPal.write = 1'b0;
   assign videoPal.wdata = '0;
   assign videoPal.addr = (hCount[2:0] == inkReqPhase) ?
                          {effAttr[7:6], 1'b0, effAttr[2:0]} :
                          {effAttr[7:6], 1'b1, effAttr[5:3]};

   always_ff @(posedge clk7) begin
      if (!rst_n)
         paperGrantQ <= 1'b0;
      else
         paperGrantQ <= videoPal.grant && (hCount[2:0] == paperReqPhase);
   end

   // Paper entry parked until the ink entry arrives
   always_ff @(posedge clk7) begin
      if (paperGrantQ)
         paperHold <= videoPal.rdata;
      if (hCount[2:0] == latchPhase) begin
         paperEntry <= paperHold;
         inkEntry <= videoPal.rdata;
         attrQ <= effAttr;
      end
   end

   ////////////////////
   // Pixel pipeline

   // Two stages line the serializer up with the latched cell
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         pixelQ1 <= 1'b0;
         pixelQ2 <= 1'b0;
      end else begin
         pixelQ1 <= pixel;
         pixelQ2 <= pixelQ1;
      end
   end

   assign stdIgrb = pixelQ2 ? {attrQ[6], attrQ[2:0]} : {attrQ[6], attrQ[5:3]};
   assign plusEntry = pixelQ2 ? inkEntry : paperEntry;

   // 332 widened to 333 by repeating the upper blue bit
   assign finalColour = ulaPlusEnabled ? {plusEntry, plusEntry[1]} : stdColour(stdIgrb);

   always_ff @(posedge clk7) begin
      if (!rst_n)
         {g, r, b} <= '0;
      else
         {g, r, b} <= finalColour;
   end

endmodule

`default_nettype wire

// ==== source/ulaIoPorts.sv ====
`timescale 1ns/1ps
`default_nettype none

module ulaIoPorts
   import ulaPkg::*;
(
   input wire logic clk7,
   input wire logic rst_n,
   input wire logic [15:0] addr,
   input wire logic iorqN,
   input wire logic rdN,
   input wire logic wrN,
   input wire logic [7:0] din,
   input wire logic ear,
   input wire logic [4:0] kbd,
   input wire logic issue2Keyboard,
   output logic [7:0] dout,
   output logic mic,
   output logic spk,
   output logic [2:0] border,
   output logic ulaPlusEnabled,
   paletteIf.client cpuPal
);

   logic ioWrite;
   logic ioRead;
   logic strobeQ;
   logic ioStart;
   logic selFe;
   logic selReg;
   logic selData;
   logic [6:0] paletteReg;
   logic [1:0] configReg;
   logic reqQ;
   logic writeQ;
   paletteIndex_t addrQ;
   paletteEntry_t wdataQ;
   logic earMix;

   ////////////////////
   // Decode

   assign ioWrite = !iorqN && !wrN;
   assign ioRead = !iorqN && !rdN;

   // Any even address is the ULA
   assign selFe = !addr[0];
   assign selReg = (addr == portUlaPlusReg);
   assign selData = (addr == portUlaPlusData);

   // First clock of a strobe
   always_ff @(posedge clk7) begin
      if (!rst_n)
         strobeQ <= 1'b0;
      else
         strobeQ <= ioWrite || ioRead;
   end

   assign ioStart = (ioWrite || ioRead) && !strobeQ;

   ////////////////////
   // Port registers

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         border <= 3'b010;
         mic <= 1'b0;
         spk <= 1'b0;
         paletteReg <= '0;
         configReg <= '0;
      end else if (ioWrite) begin
         if (selFe) begin
            border <= din[2:0];
            mic <= din[3];
            spk <= din[4];
         end else if (selReg) begin
            paletteReg <= din[6:0];
         end else if (selData && paletteReg[6]) begin
            configReg <= din[1:0];
         end
      end
   end

   assign ulaPlusEnabled = configReg[0];

   ////////////////////
   // Palette client

   // Request held until granted
   always_ff @(posedge clk7) begin
      if (!rst_n)
         reqQ <= 1'b0;
      else if (reqQ && cpuPal.grant)
         reqQ <= 1'b0;
      else if (ioStart && selData && !paletteReg[6])
         reqQ <= 1'b1;
   end

   always_ff @(posedge clk7) begin
      if (ioStart && selData && !paletteReg[6]) begin
         writeQ <= ioWrite;
         addrQ <= paletteReg[5:0];
         wdataQ <= din;
      end
   end

   assign cpuPal.req = reqQ;
   assign cpuPal.write = writeQ;
   assign cpuPal.addr = addrQ;
   assign cpuPal.wdata = wdataQ;

   ////////////////////
   // Read mux

   // Issue 2 keyboards also pick up mic on EAR
   assign earMix = ear ^ (issue2Keyboard ? (spk | mic) : spk);

   always_comb begin
      dout = 8'hFF;
      if (ioRead) begin
         if (selFe)
            dout = {1'b1, earMix, 1'b1, kbd};
         else if (selReg)
            dout = {1'b0, paletteReg};
         else if (selData)
            dout = paletteReg[6] ? {6'b000000, configReg} : cpuPal.rdata;
      end
   end

endmodule

`default_nettype wire

// ==== source/ulaTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module ulaTop
   import ulaPkg::*;
#(
   parameter int hTotal = ulaPkg::hTotal,
   parameter int vTotal = ulaPkg::vTotal
) (
   input wire logic clk7,
   input wire logic rst_n,
   // Z80 side
   input wire logic [15:0] addr,
   input wire logic iorqN,
   input wire logic rdN,
   input wire logic wrN,
   input wire logic [7:0] din,
   output logic [7:0] dout,
   output logic intN,
   // Video RAM
   output logic [13:0] vramAddr,
   input wire logic [7:0] vramData,
   // Keyboard, tape and beeper
   input wire logic ear,
   input wire logic [4:0] kbd,
   input wire logic issue2Keyboard,
   output logic mic,
   output logic spk,
   // Video out
   output logic [2:0] r,
   output logic [2:0] g,
   output logic [2:0] b,
   output logic hsync,
   output logic vsync,
   output vCount_t hCount,
   output vCount_t vCount
);

   logic pixel;
   logic [7:0] attrNext;
   logic paperActive;
   logic [2:0] border;
   logic ulaPlusEnabled;

   // One link per palette client
   paletteIf videoPal ();
   paletteIf cpuPal ();

   ulaRasterTiming #(
      .hTotal(hTotal),
      .vTotal(vTotal)
   ) raster (
      .clk7(clk7), .rst_n(rst_n), .hCount(hCount), .vCount(vCount),
      .hsync(hsync), .vsync(vsync), .intN(intN)
   );

   ulaVideoFetch fetch (
      .clk7(clk7), .rst_n(rst_n), .hCount(hCount), .vCount(vCount),
      .vramData(vramData), .vramAddr(vramAddr), .pixel(pixel),
      .attrNext(attrNext), .paperActive(paperActive)
   );

   ulaPixelColour colour (
      .clk7(clk7), .rst_n(rst_n), .hCount(hCount), .vCount(vCount),
      .pixel(pixel), .attrNext(attrNext), .paperActive(paperActive),
      .border(border), .ulaPlusEnabled(ulaPlusEnabled), .videoPal(videoPal),
      .r(r), .g(g), .b(b)
   );

   ulaIoPorts ports (
      .clk7(clk7), .rst_n(rst_n), .addr(addr), .iorqN(iorqN), .rdN(rdN),
      .wrN(wrN), .din(din), .ear(ear), .kbd(kbd), .issue2Keyboard(issue2Keyboard),
      .dout(dout), .mic(mic), .spk(spk), .border(border),
      .ulaPlusEnabled(ulaPlusEnabled), .cpuPal(cpuPal)
   );

   ulaPaletteArbiter palette (
      .clk7(clk7), .rst_n(rst_n), .videoPal(videoPal), .cpuPal(cpuPal)
   );

endmodule

`default_nettype wire

// ==== verification/ulaTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ulaTb
   import ulaPkg::*;
();

   // Frame length sets the run budget
   localparam int watchdogClocks = 3 * hTotal * vTotal + 20000;

   logic clk7;
   logic rst_n;
   logic [15:0] addr;
   logic iorqN;
   logic rdN;
   logic wrN;
   logic [7:0] din;
   logic [7:0] vramData;
   logic ear;
   logic [4:0] kbd;
   logic issue2Keyboard;
   logic [7:0] dout;
   logic [13:0] vramAddr;
   logic mic;
   logic spk;
   logic intN;
   logic [2:0] r;
   logic [2:0] g;
   logic [2:0] b;
   logic hsync;
   logic vsync;
   vCount_t hCount;
   vCount_t vCount;

   int errors = 0;
   int checks = 0;
   logic [31:0] randState = 32'd57;
   // Expected palette contents
   logic [7:0] palRef [64];

   ulaTop #(
      .hTotal(hTotal),
      .vTotal(vTotal)
   ) UUT (
      .clk7(clk7), .rst_n(rst_n), .addr(addr), .iorqN(iorqN), .rdN(rdN), .wrN(wrN),
      .din(din), .dout(dout), .intN(intN), .vramAddr(vramAddr), .vramData(vramData),
      .ear(ear), .kbd(kbd), .issue2Keyboard(issue2Keyboard), .mic(mic), .spk(spk),
      .r(r), .g(g), .b(b), .hsync(hsync), .vsync(vsync), .hCount(hCount), .vCount(vCount)
   );

   initial begin
      clk7 = 1'b0;
      forever #2 clk7 = ~clk7;
   end

   ////////////////////
   // Reference models

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // Video RAM contents as a hash of the address
   function automatic logic [7:0] vramByte(input logic [13:0] a);
      logic [31:0] s;
      s = xorshift32(32'd57 ^ {a, 16'h0000} ^ {18'd0, a});
      s = xorshift32(s);
      return s[7:0];
   endfunction

   // Synchronous video RAM with one read per clock
   always @(posedge clk7)
      vramData <= vramByte(vramAddr);

   // Channel level from its enable bit and the bright bit
   function automatic logic [2:0] channelLevel(input logic on, input logic bright);
      if (!on)
         return 3'b000;
      return bright ? 3'b111 : 3'b101;
   endfunction

   // IGRB to {g, r, b}
   function automatic logic [8:0] igrbColour(input logic [3:0] igrb);
      return {channelLevel(igrb[2], igrb[3]), channelLevel(igrb[1], igrb[3]),
              channelLevel(igrb[0], igrb[3])};
   endfunction

   // GGGRRRBB to 9 bits with upper blue bit repeated
   function automatic logic [8:0] widenEntry(input logic [7:0] e);
      return {e[7:5], e[4:2], e[1:0], e[1]};
   endfunction

   // Thirds, pixel row, character row, column
   function automatic logic [13:0] bitmapAddress(input int x, input int y);
      logic [7:0] xs;
      logic [7:0] ys;
      xs = x[7:0];
      ys = y[7:0];
      return {1'b0, ys[7:6], ys[2:0], ys[5:3], xs[7:3]};
   endfunction

   // One attribute byte per 8x8 cell from 0x1800
   function automatic logic [13:0] attrAddress(input int x, input int y);
      logic [7:0] xs;
      logic [7:0] ys;
      xs = x[7:0];
      ys = y[7:0];
      return 14'h1800 + {ys[7:3], xs[7:3]};
   endfunction

   function automatic logic [8:0] expectedPixel(input int x, input int y, input logic plus);
      logic [7:0] xs;
      logic [7:0] bm;
      logic [7:0] a;
      logic pixelOn;
      xs = x[7:0];
      bm = vramByte(bitmapAddress(x, y));
      a = vramByte(attrAddress(x, y));
      pixelOn = bm[7 - xs[2:0]];
      if (plus)
         return widenEntry(palRef[pixelOn ? {a[7:6], 1'b0, a[2:0]} : {a[7:6], 1'b1, a[5:3]}]);
      return igrbColour(pixelOn ? {a[6], a[2:0]} : {a[6], a[5:3]});
   endfunction

   ////////////////////
   // Helpers

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   // Z80 I/O write with the strobe held 4 clocks
   task automatic busWrite(input logic [15:0] port, input logic [7:0] data);
      @(posedge clk7);
      addr <= port;
      din <= data;
      iorqN <= 1'b0;
      wrN <= 1'b0;
      repeat (4) @(posedge clk7);
      iorqN <= 1'b1;
      wrN <= 1'b1;
      @(posedge clk7);
   endtask

   // Z80 I/O read with dout taken 4 clocks after the strobe
   task automatic busRead(input logic [15:0] port, output logic [7:0] data);
      @(posedge clk7);
      addr <= port;
      iorqN <= 1'b0;
      rdN <= 1'b0;
      repeat (4) @(posedge clk7);
      @(negedge clk7);
      data = dout;
      @(posedge clk7);
      iorqN <= 1'b1;
      rdN <= 1'b1;
      @(posedge clk7);
   endtask

   task automatic waitRaster(input int line, input int col);
      @(negedge clk7);
      while (!(vCount == line && hCount == col))
         @(negedge clk7);
   endtask

   ////////////////////
   // Directed tests

   task automatic portFeTest();
      logic [7:0] data;
      logic [15:0] feAddr;
      logic earBit;
      for (int m = 0; m < 4; m++) begin
         busWrite(16'h00FE, {3'b000, m[1], m[0], 3'b101});
         checkValue("mic", mic, m[0]);
         checkValue("spk", spk, m[1]);
         // ear, kbd and issue2 in every combination
         for (int i = 0; i < 128; i++) begin
            randState = xorshift32(randState);
            feAddr = {randState[15:1], 1'b0};
            @(posedge clk7);
            ear <= i[0];
            kbd <= i[5:1];
            issue2Keyboard <= i[6];
            busRead(feAddr, data);
            earBit = i[0] ^ (i[6] ? (m[1] | m[0]) : m[1]);
            checkValue("dout FE", data, {1'b1, earBit, 1'b1, i[5:1]});
         end
      end
   endtask

   task automatic paletteRegisterTest();
      logic [7:0] data;
      for (int i = 0; i < 64; i++) begin
         randState = xorshift32(randState);
         palRef[i] = randState[7:0];
         busWrite(portUlaPlusReg, i[7:0]);
         busWrite(portUlaPlusData, palRef[i]);
      end
      for (int i = 0; i < 64; i++) begin
         busWrite(portUlaPlusReg, i[7:0]);
         busRead(portUlaPlusReg, data);
         checkValue("dout BF3B", data, {2'b00, i[5:0]});
         busRead(portUlaPlusData, data);
         checkValue("dout FF3B entry", data, palRef[i]);
      end
      // Config group with ULAplus left off
      busWrite(portUlaPlusReg, 8'h40);
      busWrite(portUlaPlusData, 8'h02);
      busRead(portUlaPlusData, data);
      checkValue("dout FF3B config", data, 8'h02);
      busWrite(portUlaPlusData, 8'h00);
      busRead(portUlaPlusData, data);
      checkValue("dout FF3B config", data, 8'h00);
   endtask

   // Slot m fetches cells 2m and 2m+1, bitmap before attribute
   task automatic fetchAddressTest(input int y);
      int x;
      logic [13:0] exp;
      waitRaster(y, 0);
      for (int h = 0; h < paperWidth; h++) begin
         if (h[3]) begin
            x = {h[7:4], h[2], 3'b000};
            exp = h[1] ? attrAddress(x, y) : bitmapAddress(x, y);
            checkValue("vramAddr", vramAddr, exp);
         end
         @(negedge clk7);
      end
   endtask

   // Pixel x of one paper line is due at hCount x + pixelLead
   task automatic paperLineTest(input int y, input logic plus);
      waitRaster(y, pixelLead);
      for (int x = 0; x < paperWidth; x++) begin
         checkValue("rgb paper", {g, r, b}, expectedPixel(x, y, plus));
         @(negedge clk7);
      end
   endtask

   task automatic borderTest(input int line, input logic plus);
      logic [8:0] exp;
      waitRaster(line, 0);
      for (int c = 0; c < 8; c++) begin
         busWrite(16'h00FE, {5'b00000, c[2:0]});
         // Let the new border reach the output stage
         repeat (16) @(negedge clk7);
         exp = plus ? widenEntry(palRef[8 + c]) : igrbColour({1'b0, c[2:0]});
         repeat (4) begin
            checkValue("rgb border", {g, r, b}, exp);
            @(negedge clk7);
         end
      end
   endtask

   task automatic interruptTest();
      int h;
      int v;
      int lowCount;
      waitRaster(intLine - 1, hTotal - 16);
      h = hTotal - 16;
      v = intLine - 1;
      lowCount = 0;
      repeat (hTotal + 64) begin
         checkValue("hCount", hCount, h);
         checkValue("vCount", vCount, v);
         checkValue("intN", intN, !(v == intLine && h < intLength));
         if (!intN)
            lowCount++;
         @(negedge clk7);
         h++;
         if (h == hTotal) begin
            h = 0;
            v++;
         end
      end
      checkValue("intN low clocks", lowCount, intLength);
   endtask

   ////////////////////
   // Main sequence

   initial begin
      rst_n = 1'b0;
      addr = 16'h0000;
      iorqN = 1'b1;
      rdN = 1'b1;
      wrN = 1'b1;
      din = 8'h00;
      ear = 1'b0;
      kbd = 5'h1F;
      issue2Keyboard = 1'b0;
      vramData = 8'h00;
      repeat (2) @(posedge clk7);
      rst_n <= 1'b1;
      @(negedge clk7);
      // State right after reset
      checkValue("hCount", hCount, 0);
      checkValue("vCount", vCount, 0);
      checkValue("intN", intN, 1);
      checkValue("hsync", hsync, 0);
      checkValue("vsync", vsync, 0);
      checkValue("dout", dout, 8'hFF);
      portFeTest();
      paletteRegisterTest();
      fetchAddressTest(99);
      paperLineTest(100, 1'b0);
      borderTest(200, 1'b0);
      interruptTest();
      // ULAplus on with the loaded palette
      busWrite(portUlaPlusReg, 8'h40);
      busWrite(portUlaPlusData, 8'h01);
      borderTest(260, 1'b1);
      paperLineTest(50, 1'b1);
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

   // Watchdog
   initial begin
      repeat (watchdogClocks) @(posedge clk7);
      $display("Timeout: the tests did not finish within %0d clocks", watchdogClocks);
      $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb.f ====
source/ulaPkg.sv
source/paletteIf.sv
source/ulaRasterTiming.sv
source/ulaVideoFetch.sv
source/ulaPaletteArbiter.sv
source/ulaPixelColour.sv
source/ulaIoPorts.sv
source/ulaTop.sv
verification/ulaTb.sv
